// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   ////////////////////////////////
   // Widths and sizes
   ////////////////////////////////
   localparam int DATA_W        = 16;  // Data and instruction word
   localparam int REG_ADDR_W    = 4;   // Register select
   localparam int NUM_REGS      = 16;
   localparam int INSTR_CREDITS = 4;   // Queue depth = sender credits
   localparam int OPC_W         = 4;   // op and op_ex fields
   localparam int IMM_W         = 8;
   localparam int ALU_OP_W      = 3;
   localparam int SHAMT_W       = 4;   // Shift distance bits, next bit is direction

   ////////////////////////////////
   // Major opcodes
   ////////////////////////////////
   localparam logic [OPC_W-1:0] OP_RTYPE = 4'b0000;  // Register-register group
   localparam logic [OPC_W-1:0] OP_ANDI  = 4'b0001;
   localparam logic [OPC_W-1:0] OP_ORI   = 4'b0010;
   localparam logic [OPC_W-1:0] OP_XORI  = 4'b0011;
   localparam logic [OPC_W-1:0] OP_ADDI  = 4'b0101;
   localparam logic [OPC_W-1:0] OP_SUBI  = 4'b1001;
   localparam logic [OPC_W-1:0] OP_SHIFT = 4'b1000;  // LSH and LSHI
   localparam logic [OPC_W-1:0] OP_MOVI  = 4'b1101;
   localparam logic [OPC_W-1:0] OP_LUI   = 4'b1111;

   // Function codes carried in op_ex
   localparam logic [OPC_W-1:0] FN_AND    = 4'b0001;
   localparam logic [OPC_W-1:0] FN_OR     = 4'b0010;
   localparam logic [OPC_W-1:0] FN_XOR    = 4'b0011;
   localparam logic [OPC_W-1:0] FN_ADD    = 4'b0101;
   localparam logic [OPC_W-1:0] FN_SUB    = 4'b1001;
   localparam logic [OPC_W-1:0] FN_MOV    = 4'b1101;
   localparam logic [OPC_W-1:0] FN_LSH    = 4'b0100;  // Amount from register
   localparam logic [OPC_W-1:0] FN_LSHI_L = 4'b0000;
   localparam logic [OPC_W-1:0] FN_LSHI_R = 4'b0001;

   ////////////////////////////////
   // ALU operations
   ////////////////////////////////
   localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
   localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
   localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd5;  // MOV, MOVI, LUI
   localparam logic [ALU_OP_W-1:0] ALU_SHIFT  = 3'd6;

   // One instruction word, two field layouts
   typedef union packed
   {
      struct packed
      {
         logic [OPC_W-1:0]      op;
         logic [REG_ADDR_W-1:0] rdest;
         logic [OPC_W-1:0]      op_ex;
         logic [REG_ADDR_W-1:0] rsrc;
      } rr;                                // Register forms
      struct packed
      {
         logic [OPC_W-1:0]      op;
         logic [REG_ADDR_W-1:0] rdest;
         logic [IMM_W-1:0]      imm;
      } ri;                                // Immediate forms
   } instr_u;

endpackage

`default_nettype wire

// ==== hw/instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue
(
   input  wire         CLK,
   input  wire         rst,
   input  wire         in_valid,       // Sender holds a credit
   input  wire  [15:0] in_instr,
   output logic        q_valid,        // Head present, decode takes it
   output logic [15:0] q_instr,
   output logic        credit_return   // One pulse per pop
);

   ////////////////////////////////
   // Storage and pointers
   ////////////////////////////////
   logic [15:0] mem [0:3];             // Four entries
   logic [1:0]  wr_ptr;
   logic [1:0]  rd_ptr;
   logic [2:0]  count;                 // 0..4

   assign q_valid = (count != 3'd0);   // Decode never stalls so head pops now
   assign q_instr = mem[rd_ptr];

   // Entry storage
   always_ff @(posedge CLK)
   begin
      if (in_valid)
         mem[wr_ptr] <= in_instr;
   end

   // Pointers, occupancy and credit pulse
   always_ff @(posedge CLK)
   begin
      if (!rst)
      begin
         wr_ptr        <= 2'd0;
         rd_ptr        <= 2'd0;
         count         <= 3'd0;
         credit_return <= 1'b0;
      end
      else
      begin
         if (in_valid)
            wr_ptr <= wr_ptr + 2'd1;   // Wraps at four
         if (q_valid)
            rd_ptr <= rd_ptr + 2'd1;
         count         <= count + {2'b00, in_valid} - {2'b00, q_valid};
         credit_return <= q_valid;     // High the cycle after the pop edge
      end
   end

endmodule

`default_nettype wire

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode import cpu_pkg::*;
(
   input  wire                   CLK,
   input  wire                   rst,
   input  wire                   q_valid,     // Queue head present
   input  wire  [DATA_W-1:0]     q_instr,
   output logic [REG_ADDR_W-1:0] rd_addr_a,   // rdest read
   output logic [REG_ADDR_W-1:0] rd_addr_b,   // rsrc read
   input  wire  [DATA_W-1:0]     rd_data_a,
   input  wire  [DATA_W-1:0]     rd_data_b,
   input  wire  [DATA_W-1:0]     wb_data,     // Value now leaving execute
   output logic                  ex_valid,
   output logic [ALU_OP_W-1:0]   ex_op,
   output logic [DATA_W-1:0]     ex_a,
   output logic [DATA_W-1:0]     ex_b,
   output logic [REG_ADDR_W-1:0] ex_dest
);

   instr_u              iw;
   logic [DATA_W-1:0]   imm_sext;             // ADDI, SUBI, LSHI
   logic [DATA_W-1:0]   imm_zext;             // ANDI, ORI, XORI, MOVI
   logic [DATA_W-1:0]   imm_high;             // LUI
   logic [DATA_W-1:0]   src_a;
   logic [DATA_W-1:0]   src_b;
   logic                dec_ok;               // Encoding is one we execute
   logic [ALU_OP_W-1:0] dec_op;
   logic [DATA_W-1:0]   dec_b;

   assign iw        = q_instr;
   assign rd_addr_a = iw.rr.rdest;
   assign rd_addr_b = iw.rr.rsrc;

   assign imm_sext = {{(DATA_W-IMM_W){iw.ri.imm[IMM_W-1]}}, iw.ri.imm};
   assign imm_zext = {{(DATA_W-IMM_W){1'b0}}, iw.ri.imm};
   assign imm_high = {iw.ri.imm, {(DATA_W-IMM_W){1'b0}}};  // Low byte cleared

   ////////////////////////////////
   // Forwarding from execute
   ////////////////////////////////
   // The register file still holds the old value while execute writes it back
   assign src_a = (ex_valid && ex_dest == iw.rr.rdest) ? wb_data : rd_data_a;
   assign src_b = (ex_valid && ex_dest == iw.rr.rsrc)  ? wb_data : rd_data_b;

   ////////////////////////////////
   // Opcode decode
   ////////////////////////////////
   always_comb
   begin
      dec_ok = 1'b1;
      dec_op = ALU_ADD;
      dec_b  = src_b;
      case (iw.rr.op)
         OP_RTYPE:
         begin
            case (iw.rr.op_ex)
               FN_ADD:  dec_op = ALU_ADD;
               FN_SUB:  dec_op = ALU_SUB;
               FN_AND:  dec_op = ALU_AND;
               FN_OR:   dec_op = ALU_OR;
               FN_XOR:  dec_op = ALU_XOR;
               FN_MOV:  dec_op = ALU_PASS_B;
               default: dec_ok = 1'b0;        // No-op
            endcase
         end
         OP_ADDI:
         begin
            dec_op = ALU_ADD;
            dec_b  = imm_sext;
         end
         OP_SUBI:
         begin
            dec_op = ALU_SUB;
            dec_b  = imm_sext;
         end
         OP_ANDI:
         begin
            dec_op = ALU_AND;
            dec_b  = imm_zext;
         end
         OP_ORI:
         begin
            dec_op = ALU_OR;
            dec_b  = imm_zext;
         end
         OP_XORI:
         begin
            dec_op = ALU_XOR;
            dec_b  = imm_zext;
         end
         OP_SHIFT:
         begin
            dec_op = ALU_SHIFT;
            case (iw.rr.op_ex)
               FN_LSH:    dec_b = src_b;      // Amount and direction from rsrc
               FN_LSHI_L: dec_b = imm_sext;   // imm bit 4 = op_ex bit 0 = direction
               FN_LSHI_R: dec_b = imm_sext;
               default:   dec_ok = 1'b0;
            endcase
         end
         OP_MOVI:
         begin
            dec_op = ALU_PASS_B;
            dec_b  = imm_zext;
         end
         OP_LUI:
         begin
            dec_op = ALU_PASS_B;
            dec_b  = imm_high;
         end
         default: dec_ok = 1'b0;
      endcase
   end

   ////////////////////////////////
   // Decode stage register
   ////////////////////////////////
   always_ff @(posedge CLK)
   begin
      if (!rst)
         ex_valid <= 1'b0;
      else
         ex_valid <= q_valid && dec_ok;     // Undefined encodings drop here
   end

   always_ff @(posedge CLK)
   begin
      if (q_valid)
      begin
         ex_op   <= dec_op;
         ex_a    <= src_a;                  // Operand a is always rdest
         ex_b    <= dec_b;
         ex_dest <= iw.rr.rdest;
      end
   end

endmodule

`default_nettype wire

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute import cpu_pkg::*;
(
   input  wire                   ex_valid,
   input  wire  [ALU_OP_W-1:0]   ex_op,
   input  wire  [DATA_W-1:0]     ex_a,       // rdest value
   input  wire  [DATA_W-1:0]     ex_b,       // rsrc or immediate
   input  wire  [REG_ADDR_W-1:0] ex_dest,
   output logic                  wb_valid,
   output logic [REG_ADDR_W-1:0] wb_dest,
   output logic [DATA_W-1:0]     wb_data     // Also the forwarding source
);

   logic [SHAMT_W-1:0] shamt;
   logic               shift_right;
   logic [DATA_W-1:0]  stage [0:SHAMT_W];    // Barrel shifter levels
   logic [DATA_W-1:0]  shift_out;

   assign shamt       = ex_b[SHAMT_W-1:0];
   assign shift_right = ex_b[SHAMT_W];       // 0 left, 1 right

   ////////////////////////////////
   // Barrel shifter
   ////////////////////////////////
   // Level i moves by 2**i when amount bit i is set, logical in both directions
   always_comb
   begin
      stage[0] = ex_a;
      for (int i = 0; i < SHAMT_W; i++)
      begin
         if (!shamt[i])
            stage[i+1] = stage[i];
         else if (shift_right)
            stage[i+1] = stage[i] >> (1 << i);
         else
            stage[i+1] = stage[i] << (1 << i);
      end
   end

   assign shift_out = stage[SHAMT_W];

   ////////////////////////////////
   // Result select
   ////////////////////////////////
   always_comb
   begin
      case (ex_op)
         ALU_ADD:    wb_data = ex_a + ex_b;   // Carry dropped
         ALU_SUB:    wb_data = ex_a - ex_b;
         ALU_AND:    wb_data = ex_a & ex_b;
         ALU_OR:     wb_data = ex_a | ex_b;
         ALU_XOR:    wb_data = ex_a ^ ex_b;
         ALU_PASS_B: wb_data = ex_b;          // MOV, MOVI, LUI
         ALU_SHIFT:  wb_data = shift_out;
         default:    wb_data = '0;            // Code 7 unused
      endcase
   end

   // Control rides along with the value
   assign wb_valid = ex_valid;
   assign wb_dest  = ex_dest;

endmodule

`default_nettype wire

// ==== hw/writeback_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_regfile import cpu_pkg::*;
(
   input  wire                   CLK,
   input  wire                   rst,
   input  wire  [REG_ADDR_W-1:0] rd_addr_a,
   input  wire  [REG_ADDR_W-1:0] rd_addr_b,
   output logic [DATA_W-1:0]     rd_data_a,    // Combinational reads
   output logic [DATA_W-1:0]     rd_data_b,
   input  wire                   wb_valid,
   input  wire  [REG_ADDR_W-1:0] wb_dest,
   input  wire  [DATA_W-1:0]     wb_data,
   output logic                  result_valid,
   output logic [REG_ADDR_W-1:0] result_reg,
   output logic [DATA_W-1:0]     result
);

   logic [DATA_W-1:0] regs [0:NUM_REGS-1];

   // Old contents during a write, decode forwards the new one
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

   ////////////////////////////////
   // Register write
   ////////////////////////////////
   always_ff @(posedge CLK)
   begin
      if (!rst)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;                     // All registers read zero
         result_valid <= 1'b0;
      end
      else
      begin
         if (wb_valid)
            regs[wb_dest] <= wb_data;
         result_valid <= wb_valid;
      end
   end

   // Result port mirrors the write
   always_ff @(posedge CLK)
   begin
      if (wb_valid)
      begin
         result_reg <= wb_dest;
         result     <= wb_data;
      end
   end

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*;
(
   input  wire                   CLK,
   input  wire                   rst,
   input  wire                   in_valid,       // Needs a sender credit
   input  wire  [DATA_W-1:0]     in_instr,
   output logic                  credit_return,
   output logic                  result_valid,   // Two edges after acceptance
   output logic [REG_ADDR_W-1:0] result_reg,
   output logic [DATA_W-1:0]     result
);

   ////////////////////////////////
   // Stage wiring
   ////////////////////////////////
   logic                  q_valid;
   logic [DATA_W-1:0]     q_instr;
   logic [REG_ADDR_W-1:0] rd_addr_a;
   logic [REG_ADDR_W-1:0] rd_addr_b;
   logic [DATA_W-1:0]     rd_data_a;
   logic [DATA_W-1:0]     rd_data_b;
   logic                  ex_valid;
   logic [ALU_OP_W-1:0]   ex_op;
   logic [DATA_W-1:0]     ex_a;
   logic [DATA_W-1:0]     ex_b;
   logic [REG_ADDR_W-1:0] ex_dest;
   logic                  wb_valid;
   logic [REG_ADDR_W-1:0] wb_dest;
   logic [DATA_W-1:0]     wb_data;

   instr_queue u_queue
   (
      .CLK           (CLK),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_instr      (in_instr),
      .q_valid       (q_valid),
      .q_instr       (q_instr),
      .credit_return (credit_return)
   );

   instr_decode u_decode
   (
      .CLK       (CLK),
      .rst       (rst),
      .q_valid   (q_valid),
      .q_instr   (q_instr),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wb_data   (wb_data),        // Forwarding path
      .ex_valid  (ex_valid),
      .ex_op     (ex_op),
      .ex_a      (ex_a),
      .ex_b      (ex_b),
      .ex_dest   (ex_dest)
   );

   alu_execute u_execute
   (
      .ex_valid (ex_valid),
      .ex_op    (ex_op),
      .ex_a     (ex_a),
      .ex_b     (ex_b),
      .ex_dest  (ex_dest),
      .wb_valid (wb_valid),
      .wb_dest  (wb_dest),
      .wb_data  (wb_data)
   );

   writeback_regfile u_regfile
   (
      .CLK          (CLK),
      .rst          (rst),
      .rd_addr_a    (rd_addr_a),
      .rd_addr_b    (rd_addr_b),
      .rd_data_a    (rd_data_a),
      .rd_data_b    (rd_data_b),
      .wb_valid     (wb_valid),
      .wb_dest      (wb_dest),
      .wb_data      (wb_data),
      .result_valid (result_valid),
      .result_reg   (result_reg),
      .result       (result)
   );

endmodule

`default_nettype wire

// ==== sim/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_properties
(
   input wire CLK,
   input wire rst,
   input wire in_valid,        // Acceptance, sender holds a credit
   input wire credit_return,
   input wire result_valid
);

   ////////////////////////////////
   // Reset behavior
   ////////////////////////////////
   // Every reset edge leaves both outputs low for the following cycle
   reset_quiet: assert property (@(posedge CLK)
      !rst |=> (!result_valid && !credit_return))
      else $error("result_valid or credit_return high in or just after reset");

   ////////////////////////////////
   // Credit and result timing
   ////////////////////////////////
   // Pop one edge after acceptance, pulse seen at the edge after that
   credit_follows_accept: assert property (@(posedge CLK) disable iff (!rst)
      credit_return == $past(in_valid, 2))
      else $error("credit_return does not follow an accepted instruction");

   // Result is written two edges after acceptance
   result_has_source: assert property (@(posedge CLK) disable iff (!rst)
      result_valid |-> $past(in_valid, 3))
      else $error("result_valid without an instruction accepted two edges before");

endmodule

bind cpu_top cpu_properties u_props
(
   .CLK           (CLK),
   .rst           (rst),
   .in_valid      (in_valid),
   .credit_return (credit_return),
   .result_valid  (result_valid)
);

`default_nettype wire

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*;
();

   localparam int CLK_PERIOD   = 4;                    // ns
   localparam int NUM_DIRECTED = 32;
   localparam int NUM_RANDOM   = 200;
   localparam int NUM_INSTR    = NUM_DIRECTED + NUM_RANDOM;
   localparam int WATCHDOG_NS  = (NUM_INSTR + 20) * CLK_PERIOD * 4;

   logic                  CLK = 1'b0;
   logic                  rst;
   logic                  in_valid;
   logic [DATA_W-1:0]     in_instr;
   logic                  credit_return;
   logic                  result_valid;
   logic [REG_ADDR_W-1:0] result_reg;
   logic [DATA_W-1:0]     result;

   logic [31:0]           lcg_state;
   int                    edge_cnt;                    // Rising edges so far
   int                    credits;                     // Sender side count
   logic [DATA_W-1:0]     model_regs [0:NUM_REGS-1];
   int                    credit_due_q [$];            // Edge that sets credit_return
   int                    res_due_q [$];               // Edge that sets result_valid
   logic [REG_ADDR_W-1:0] res_reg_q [$];
   logic [DATA_W-1:0]     res_val_q [$];

   cpu_top dut
   (
      .CLK           (CLK),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_instr      (in_instr),
      .credit_return (credit_return),
      .result_valid  (result_valid),
      .result_reg    (result_reg),
      .result        (result)
   );

   initial
   begin
      forever #(CLK_PERIOD/2) CLK = ~CLK;
   end

   always @(posedge CLK)
      edge_cnt++;

   ////////////////////////////////
   // Error exits
   ////////////////////////////////
   task automatic stop_on_error();
      $display("=== FAIL ===");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
      $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
      stop_on_error();
   endtask

   ////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////
   function automatic logic [15:0] lcg_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];                         // Upper bits spread better
   endfunction

   function automatic logic [DATA_W-1:0] rr_word(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [3:0] fn, input logic [3:0] rs);
      instr_u w;
      w.rr.op    = op;
      w.rr.rdest = rd;
      w.rr.op_ex = fn;
      w.rr.rsrc  = rs;
      return w;
   endfunction

   function automatic logic [DATA_W-1:0] imm_word(input logic [3:0] op, input logic [3:0] rd,
                                                  input logic [7:0] imm);
      instr_u w;
      w.ri.op    = op;
      w.ri.rdest = rd;
      w.ri.imm   = imm;
      return w;
   endfunction

   function automatic logic [DATA_W-1:0] random_instr();
      logic [15:0] f;
      logic [15:0] r;
      logic [3:0]  rd;
      logic [3:0]  rs;
      logic [7:0]  imm;
      f   = lcg_rand();
      r   = lcg_rand();
      rd  = f[11:8] % 4'd6;                            // Few registers so many dependences
      rs  = f[7:4] % 4'd6;
      imm = r[7:0];
      case (f[15:12])
         4'd0:    return rr_word(OP_RTYPE, rd, FN_ADD, rs);
         4'd1:    return rr_word(OP_RTYPE, rd, FN_SUB, rs);
         4'd2:    return rr_word(OP_RTYPE, rd, FN_AND, rs);
         4'd3:    return rr_word(OP_RTYPE, rd, FN_OR, rs);
         4'd4:    return rr_word(OP_RTYPE, rd, FN_XOR, rs);
         4'd5:    return rr_word(OP_RTYPE, rd, FN_MOV, rs);
         4'd6:    return imm_word(OP_ADDI, rd, imm);
         4'd7:    return imm_word(OP_SUBI, rd, imm);
         4'd8:    return imm_word(OP_ANDI, rd, imm);
         4'd9:    return imm_word(OP_ORI, rd, imm);
         4'd10:   return imm_word(OP_XORI, rd, imm);
         4'd11:   return imm_word(OP_MOVI, rd, imm);
         4'd12:   return imm_word(OP_LUI, rd, imm);
         4'd13:   return rr_word(OP_SHIFT, rd, FN_LSH, rs);
         4'd14:   return rr_word(OP_SHIFT, rd, {3'b000, imm[4]}, imm[3:0]);  // LSHI
         default: return r;                            // Raw word that is often undefined
      endcase
   endfunction

   ////////////////////////////////
   // Reference model
   ////////////////////////////////
   function automatic logic [DATA_W-1:0] shift_ref(input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] amt);
      if (amt[4])
         return a >> amt[3:0];                         // Bit 4 set shifts right
      else
         return a << amt[3:0];
   endfunction

   // Returns 1 when the word writes a register
   function automatic logic model_exec(input logic [DATA_W-1:0] word,
                                       output logic [DATA_W-1:0] value);
      instr_u            w;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] imm_z;
      logic [DATA_W-1:0] imm_s;
      logic              ok;
      w     = word;
      a     = model_regs[w.rr.rdest];
      b     = model_regs[w.rr.rsrc];
      imm_z = {8'h00, w.ri.imm};
      imm_s = {{8{w.ri.imm[7]}}, w.ri.imm};
      ok    = 1'b1;
      value = '0;
      case (w.rr.op)
         OP_RTYPE:
         begin
            case (w.rr.op_ex)
               FN_ADD:  value = a + b;                 // Truncated to 16 bits
               FN_SUB:  value = a - b;
               FN_AND:  value = a & b;
               FN_OR:   value = a | b;
               FN_XOR:  value = a ^ b;
               FN_MOV:  value = b;
               default: ok = 1'b0;
            endcase
         end
         OP_ADDI: value = a + imm_s;
         OP_SUBI: value = a - imm_s;
         OP_ANDI: value = a & imm_z;
         OP_ORI:  value = a | imm_z;
         OP_XORI: value = a ^ imm_z;
         OP_MOVI: value = imm_z;
         OP_LUI:  value = {w.ri.imm, 8'h00};           // Low byte cleared
         OP_SHIFT:
         begin
            if (w.rr.op_ex == FN_LSH)
               value = shift_ref(a, b);
            else if (w.rr.op_ex == FN_LSHI_L || w.rr.op_ex == FN_LSHI_R)
               value = shift_ref(a, imm_z);
            else
               ok = 1'b0;
         end
         default: ok = 1'b0;
      endcase
      return ok;
   endfunction

   ////////////////////////////////
   // One falling edge that checks then drives
   ////////////////////////////////
   task automatic step_cycle(input logic want, input logic [DATA_W-1:0] word,
                             output logic sent);
      logic              exp_credit;
      logic              exp_res;
      logic [DATA_W-1:0] value;
      instr_u            w;
      @(negedge CLK);
      exp_credit = (credit_due_q.size() > 0) && (credit_due_q[0] == edge_cnt);
      assert (credit_return === exp_credit)
         else value_mismatch("credit_return", exp_credit, credit_return);
      if (exp_credit)
         void'(credit_due_q.pop_front());
      if (credit_return)
         credits++;                                    // Credit back
      exp_res = (res_due_q.size() > 0) && (res_due_q[0] == edge_cnt);
      assert (result_valid === exp_res)
         else value_mismatch("result_valid", exp_res, result_valid);
      if (exp_res)
      begin
         assert (result_reg === res_reg_q[0])
            else value_mismatch("result_reg", res_reg_q[0], result_reg);
         assert (result === res_val_q[0])
            else value_mismatch("result", res_val_q[0], result);
         void'(res_due_q.pop_front());
         void'(res_reg_q.pop_front());
         void'(res_val_q.pop_front());
      end
      sent     = want && (credits > 0);                // Only with a credit in hand
      in_valid = sent;
      in_instr = word;
      if (sent)
      begin
         credits--;
         credit_due_q.push_back(edge_cnt + 2);         // Accepted at edge_cnt + 1
         w = word;
         if (model_exec(word, value))
         begin
            model_regs[w.rr.rdest] = value;            // Acceptance order
            res_due_q.push_back(edge_cnt + 3);
            res_reg_q.push_back(w.rr.rdest);
            res_val_q.push_back(value);
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      logic sent;
      repeat (n)
         step_cycle(1'b0, '0, sent);
   endtask

   task automatic send_instr(input logic [DATA_W-1:0] word);
      logic sent;
      sent = 1'b0;
      while (!sent)
         step_cycle(1'b1, word, sent);                 // Retry until a credit is free
   endtask

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////
   initial
   begin
      logic [15:0] r;
      lcg_state = 32'd78275;
      edge_cnt  = 0;
      credits   = INSTR_CREDITS;
      rst       = 1'b0;
      in_valid  = 1'b0;
      in_instr  = '0;
      for (int i = 0; i < NUM_REGS; i++)
         model_regs[i] = '0;
      idle_cycles(2);                                  // Two reset edges
      rst = 1'b1;
      idle_cycles(4);                                  // Quiet after reset

      // Registers start at zero
      send_instr(rr_word(OP_RTYPE, 4'd1, FN_ADD, 4'd2));
      send_instr(imm_word(OP_ORI, 4'd3, 8'h5a));
      // Immediate forms
      send_instr(imm_word(OP_MOVI, 4'd4, 8'h80));
      send_instr(imm_word(OP_ADDI, 4'd5, 8'h80));     // Sign extended
      send_instr(imm_word(OP_SUBI, 4'd6, 8'hff));
      send_instr(imm_word(OP_LUI, 4'd7, 8'ha5));
      send_instr(imm_word(OP_ORI, 4'd7, 8'hc3));
      send_instr(imm_word(OP_ANDI, 4'd7, 8'h0f));     // Upper byte cleared
      send_instr(imm_word(OP_XORI, 4'd4, 8'hff));
      // Register forms
      send_instr(rr_word(OP_RTYPE, 4'd5, FN_ADD, 4'd4));
      send_instr(rr_word(OP_RTYPE, 4'd5, FN_ADD, 4'd6));  // Carry out dropped
      send_instr(rr_word(OP_RTYPE, 4'd6, FN_SUB, 4'd7));
      send_instr(rr_word(OP_RTYPE, 4'd6, FN_AND, 4'd3));
      send_instr(rr_word(OP_RTYPE, 4'd8, FN_OR, 4'd7));
      send_instr(rr_word(OP_RTYPE, 4'd8, FN_XOR, 4'd6));
      send_instr(rr_word(OP_RTYPE, 4'd9, FN_MOV, 4'd6));
      // Shifts
      send_instr(imm_word(OP_LUI, 4'd10, 8'h81));
      send_instr(rr_word(OP_SHIFT, 4'd10, FN_LSHI_L, 4'd3));
      send_instr(rr_word(OP_SHIFT, 4'd10, FN_LSHI_R, 4'd9));
      send_instr(imm_word(OP_MOVI, 4'd11, 8'h12));    // Right by two
      send_instr(rr_word(OP_SHIFT, 4'd10, FN_LSH, 4'd11));
      send_instr(imm_word(OP_MOVI, 4'd11, 8'h0f));    // Left by fifteen
      send_instr(rr_word(OP_SHIFT, 4'd10, FN_LSH, 4'd11));
      // Undefined encodings return only a credit
      send_instr(rr_word(OP_RTYPE, 4'd1, 4'b0111, 4'd2));
      send_instr(imm_word(4'b0100, 4'd1, 8'h33));
      send_instr(rr_word(OP_SHIFT, 4'd1, 4'b1010, 4'd2));
      // Dependent burst through forwarding
      send_instr(imm_word(OP_MOVI, 4'd12, 8'h01));
      send_instr(rr_word(OP_RTYPE, 4'd12, FN_ADD, 4'd12));
      send_instr(rr_word(OP_RTYPE, 4'd12, FN_ADD, 4'd12));
      send_instr(rr_word(OP_RTYPE, 4'd13, FN_MOV, 4'd12));
      send_instr(rr_word(OP_SHIFT, 4'd12, FN_LSH, 4'd13));
      send_instr(rr_word(OP_RTYPE, 4'd13, FN_XOR, 4'd12));

      // Random run with gaps and bursts
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         r = lcg_rand();
         if (r[1:0] == 2'd0)
            idle_cycles(1 + int'(r[3:2]));
         send_instr(random_instr());
      end

      idle_cycles(8);                                  // Drain pipeline and credits
      if (res_due_q.size() == 0 && credit_due_q.size() == 0 && credits == INSTR_CREDITS)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("run ended with %0d results and %0d credits outstanding",
                  res_due_q.size(), INSTR_CREDITS - credits);
         stop_on_error();
      end
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
      stop_on_error();
   end

endmodule

`default_nettype wire

// ==== src.f ====
hw/cpu_pkg.sv
hw/instr_queue.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/writeback_regfile.sv
hw/cpu_top.sv
sim/cpu_properties.sv
sim/cpu_tb.sv
